// ==== tb.f ====
mcb_pkg.sv
stage_if.sv
cmd_tracker.sv
stage_sequencer.sv
wb_burst_master.sv
word_fifo.sv
sdram_mcb.sv
tb_clkgen.sv
tb_sdram_mcb.sv

// ==== run.sh ====
#!/bin/sh
verilator --binary --timing --assert -f tb.f --top-module tb_sdram_mcb -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "TEST RESULT: PASS" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== tb_sdram_mcb.sv ====
`timescale 1ns/1ps

module tb_sdram_mcb;

    logic                       clk_sdram;
    logic                       rst_n;
    logic                       wr_load;
    logic [mcb_pkg::ADDR_W-1:0] wr_addr;
    logic [mcb_pkg::ADDR_W-1:0] wr_length;
    logic                       wr_req;
    mcb_pkg::word_t             din;
    logic                       wr_done;
    logic                       wr_rdy;
    logic                       rd_load;
    logic [mcb_pkg::ADDR_W-1:0] rd_addr;
    logic [mcb_pkg::ADDR_W-1:0] rd_length;
    logic                       rd_req;
    mcb_pkg::word_t             dout;
    logic                       rd_done;
    mcb_pkg::fifo_cnt_t         rd_fifo_cnt;
    logic                       rd_fifo_empty;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [mcb_pkg::ADDR_W-1:0] wb_adr;
    mcb_pkg::word_t             wb_dat_w;
    mcb_pkg::word_t             wb_dat_r;
    logic                       wb_ack;

    integer         seed = 95983;
    mcb_pkg::word_t mem_model [int];   // memory contents by flat address
    mcb_pkg::word_t wr_expect [$];     // pushed words not yet on the bus
    mcb_pkg::word_t rd_expect [$];     // read words not yet popped
    mcb_pkg::len_t  wr_m_addr;         // next expected write beat address
    mcb_pkg::len_t  rd_m_addr;
    int             wr_rem;            // words of the write still to beat
    int             rd_rem;
    int             push_left;         // words still to hand the write FIFO
    int             rd_cnt_model;
    int             wr_done_cnt;
    int             rd_done_cnt;
    int             cycles;
    int             limit;
    bit             pop_always;        // drain the read FIFO every cycle
    bit             alt_check;
    mcb_pkg::len_t  t_addr [3];
    int             t_len [3];
    int             r_off [2];
    int             r_len [2];

    tb_clkgen u_clk (.clk_sdram (clk_sdram), .rst_n (rst_n));

    sdram_mcb u_dut (.*);

    function automatic mcb_pkg::word_t fill_word(input mcb_pkg::len_t a);
        return a[15:0] ^ {a[23:16], a[23:16]} ^ 16'h5a5a;   // never written cells
    endfunction

    // words of the next stage up to the end of its 512-word page
    function automatic int page_stage(input mcb_pkg::len_t a, input int rem);
        int room;
        room = 512 - int'(a[8:0]);
        return (rem < room) ? rem : room;
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input mcb_pkg::word_t got,
                              input mcb_pkg::word_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR t=%0t %s got %h expected %h", $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input mcb_pkg::sdram_addr_u got,
                              input mcb_pkg::sdram_addr_u exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR t=%0t %s got %h expected %h", $time, name,
                               got.flat, exp.flat));
        end
    endtask

    task automatic check_count(input string name, input mcb_pkg::fifo_cnt_t got,
                               input mcb_pkg::fifo_cnt_t exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR t=%0t %s got %0d expected %0d", $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            stop_run($sformatf("ERROR t=%0t %s got %b expected %b", $time, name, got, exp));
        end
    endtask

    task automatic load_txn(input bit do_wr, input mcb_pkg::len_t wa, input int wn,
                            input bit do_rd, input mcb_pkg::len_t ra, input int rn);
        @(negedge clk_sdram);
        wr_load   = do_wr;
        wr_addr   = wa;
        wr_length = mcb_pkg::len_t'(wn);
        rd_load   = do_rd;
        rd_addr   = ra;
        rd_length = mcb_pkg::len_t'(rn);
        @(negedge clk_sdram);
        wr_load = 1'b0;                      // single-cycle load pulses
        rd_load = 1'b0;
    endtask

    task automatic wait_done(input int wr_target, input int rd_target);
        while (wr_done_cnt < wr_target || rd_done_cnt < rd_target || push_left != 0 ||
               rd_expect.size() != 0 || rd_cnt_model != 0) begin
            @(posedge clk_sdram);
        end
    endtask

    initial begin
        wr_load    = 1'b0;
        wr_addr    = '0;
        wr_length  = '0;
        rd_load    = 1'b0;
        rd_addr    = '0;
        rd_length  = '0;
        wr_rem     = 0;
        rd_rem     = 0;
        push_left  = 0;
        pop_always = 1'b0;
        alt_check  = 1'b0;
        for (int i = 0; i < 2; i++) begin
            t_addr[i] = mcb_pkg::len_t'($random(seed));
            t_len[i]  = (i == 0) ? 1000 + ($unsigned($random(seed)) % 501)  // covers later read
                                 : 1 + ($unsigned($random(seed)) % 1500);
            r_off[i]  = $unsigned($random(seed)) % t_len[i];
            r_len[i]  = 1 + ($unsigned($random(seed)) % (t_len[i] - r_off[i]));
        end
        t_addr[2] = mcb_pkg::len_t'($random(seed)) & ~mcb_pkg::len_t'(511);  // page aligned
        t_len[2]  = 1000;
        limit     = (t_len[0] + t_len[1] + r_len[0] + r_len[1] + 2000) * 12 + 2000;
        wait (rst_n);
        @(negedge clk_sdram);
        check_bit("wb_cyc", wb_cyc, 1'b0);
        check_bit("wb_stb", wb_stb, 1'b0);
        check_bit("wr_done", wr_done, 1'b0);
        check_bit("rd_done", rd_done, 1'b0);
        check_bit("rd_fifo_empty", rd_fifo_empty, 1'b1);
        check_count("rd_fifo_cnt", rd_fifo_cnt, '0);
        @(posedge clk_sdram);
        for (int r = 0; r < 2; r++) begin
            wr_m_addr = t_addr[r];
            wr_rem    = t_len[r];
            push_left = t_len[r];
            load_txn(1'b1, t_addr[r], t_len[r], 1'b0, '0, 0);
            load_txn(1'b1, t_addr[r] ^ 24'h000100, 5, 1'b0, '0, 0);  // lands while pending
            wait_done(r + 1, r);
            rd_m_addr = t_addr[r] + mcb_pkg::len_t'(r_off[r]);
            rd_rem    = r_len[r];
            load_txn(1'b0, '0, 0, 1'b1, rd_m_addr, r_len[r]);
            wait_done(r + 1, r + 1);
        end
        pop_always = 1'b1;
        push_left  = t_len[2];               // prefill before either load
        while (push_left != 0) begin
            @(posedge clk_sdram);
        end
        wr_m_addr = t_addr[2];
        wr_rem    = t_len[2];
        rd_m_addr = t_addr[0];
        rd_rem    = 1000;
        alt_check = 1'b1;
        load_txn(1'b1, t_addr[2], t_len[2], 1'b1, t_addr[0], 1000);
        wait_done(3, 3);
        repeat (4) @(posedge clk_sdram);     // room for a stray extra pulse
        check_count("wr_done pulses", mcb_pkg::fifo_cnt_t'(wr_done_cnt), 3);
        check_count("rd_done pulses", mcb_pkg::fifo_cnt_t'(rd_done_cnt), 3);
        $display("TEST RESULT: PASS");
        $finish;
    end

    initial begin
        cycles = 0;
        wait (rst_n);
        while (cycles <= limit) begin
            @(posedge clk_sdram);
            cycles++;
        end
        stop_run("timeout: transactions did not finish within the cycle limit");
    end

    // user-side driver, Wishbone memory model and checks
    initial begin : bus_model
        int            wait_left;
        int            beats;
        int            exp_len;
        int            alt_stages;
        bit            cyc_q;
        bit            stage_we;
        bit            last_we;
        bit            pop_now;
        bit            push_now;
        mcb_pkg::len_t a;
        wr_req       = 1'b0;
        din          = '0;
        rd_req       = 1'b0;
        wb_ack       = 1'b0;
        wb_dat_r     = '0;
        rd_cnt_model = 0;
        wr_done_cnt  = 0;
        rd_done_cnt  = 0;
        cyc_q        = 1'b0;
        last_we      = 1'b0;
        beats        = 0;
        exp_len      = 0;
        alt_stages   = 0;
        wait (rst_n);
        wait_left = $unsigned($random(seed)) % 4;
        forever begin
            @(negedge clk_sdram);
            check_count("rd_fifo_cnt", rd_fifo_cnt, mcb_pkg::fifo_cnt_t'(rd_cnt_model));
            check_bit("rd_fifo_empty", rd_fifo_empty, rd_cnt_model == 0);
            check_bit("wr_rdy", wr_rdy, wr_expect.size() < mcb_pkg::FIFO_DEPTH);
            if (wr_done) begin
                if (wr_rem != 0) begin
                    stop_run("wr_done pulsed before the final write beat");
                end
                wr_done_cnt++;
            end
            if (rd_done) begin
                if (rd_rem != 0) begin
                    stop_run("rd_done pulsed before the final read beat");
                end
                rd_done_cnt++;
            end
            wr_req = 1'b0;
            if (push_left > 0) begin
                din    = mcb_pkg::word_t'($random(seed));
                wr_req = 1'b1;
                if (wr_rdy) begin            // accepted at the next rising edge
                    wr_expect.push_back(din);
                    push_left--;
                end
            end
            pop_now = !rd_fifo_empty && (pop_always || (($random(seed) & 1) != 0));
            rd_req  = pop_now;
            if (pop_now) begin
                if (rd_expect.size() == 0) begin
                    stop_run("read FIFO shows a word that no read beat brought in");
                end else begin
                    check_word("dout", dout, rd_expect.pop_front());
                end
            end
            if (wb_cyc && !cyc_q) begin      // new stage
                stage_we = wb_we;
                beats    = 0;
                a        = stage_we ? wr_m_addr : rd_m_addr;
                exp_len  = page_stage(a, stage_we ? wr_rem : rd_rem);
                check_addr("wb_adr at stage start", mcb_pkg::sdram_addr_u'(wb_adr),
                           mcb_pkg::sdram_addr_u'(a));
                if (alt_check && alt_stages > 0 && (last_we ? rd_rem : wr_rem) > 0) begin
                    check_bit("wb_we alternation", wb_we, !last_we);
                end
            end
            if (!wb_cyc && cyc_q) begin      // stage ended
                check_count("stage beat count", mcb_pkg::fifo_cnt_t'(beats),
                            mcb_pkg::fifo_cnt_t'(exp_len));
                last_we = stage_we;
                if (alt_check) begin
                    alt_stages++;
                end
            end
            cyc_q    = wb_cyc;
            wb_ack   = 1'b0;
            push_now = 1'b0;
            if (wb_cyc && wb_stb) begin
                if (wait_left > 0) begin
                    wait_left--;             // slave wait state
                end else begin
                    a = wb_adr;
                    check_addr("wb_adr", mcb_pkg::sdram_addr_u'(wb_adr),
                               mcb_pkg::sdram_addr_u'(wb_we ? wr_m_addr : rd_m_addr));
                    if (wb_we) begin
                        if (wr_expect.size() == 0) begin
                            stop_run("write beat with no pushed word left");
                        end else begin
                            check_word("wb_dat_w", wb_dat_w, wr_expect.pop_front());
                            mem_model[int'(a)] = wb_dat_w;
                            wr_m_addr++;
                            wr_rem--;
                        end
                    end else begin
                        wb_dat_r = mem_model.exists(int'(a)) ? mem_model[int'(a)] : fill_word(a);
                        rd_expect.push_back(wb_dat_r);
                        push_now = 1'b1;
                        rd_m_addr++;
                        rd_rem--;
                    end
                    beats++;
                    wb_ack    = 1'b1;
                    wait_left = $unsigned($random(seed)) % 4;
                end
            end
            rd_cnt_model = rd_cnt_model + int'(push_now) - int'(pop_now);
        end
    end

endmodule

// ==== tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_sdram,
    output logic rst_n
);

    initial begin
        clk_sdram = 1'b0;
        forever #20 clk_sdram = ~clk_sdram;   // 40 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk_sdram);      // three cycles in reset
        @(negedge clk_sdram);
        rst_n = 1'b1;
    end

endmodule

// ==== sdram_mcb.sv ====
`timescale 1ns/1ps

module sdram_mcb (
    input  logic                        clk_sdram,
    input  logic                        rst_n,
    // write side
    input  logic                        wr_load,
    input  logic [mcb_pkg::ADDR_W-1:0]  wr_addr,     // {bank, row, col}
    input  logic [mcb_pkg::ADDR_W-1:0]  wr_length,   // words
    input  logic                        wr_req,
    input  logic [mcb_pkg::DATA_W-1:0]  din,
    output logic                        wr_done,
    output logic                        wr_rdy,
    // read side
    input  logic                        rd_load,
    input  logic [mcb_pkg::ADDR_W-1:0]  rd_addr,
    input  logic [mcb_pkg::ADDR_W-1:0]  rd_length,
    input  logic                        rd_req,
    output logic [mcb_pkg::DATA_W-1:0]  dout,
    output logic                        rd_done,
    output logic [mcb_pkg::CNT_W-1:0]   rd_fifo_cnt,
    output logic                        rd_fifo_empty,
    // Wishbone classic master
    output logic                        wb_cyc,
    output logic                        wb_stb,
    output logic                        wb_we,
    output logic [mcb_pkg::ADDR_W-1:0]  wb_adr,
    output logic [mcb_pkg::DATA_W-1:0]  wb_dat_w,
    input  logic [mcb_pkg::DATA_W-1:0]  wb_dat_r,
    input  logic                        wb_ack
);

    mcb_pkg::sdram_addr_u wr_cur_addr;
    mcb_pkg::sdram_addr_u rd_cur_addr;
    mcb_pkg::stage_len_t  wr_stage_len;
    mcb_pkg::stage_len_t  rd_stage_len;
    mcb_pkg::fifo_cnt_t   wr_fifo_cnt;
    mcb_pkg::word_t       wr_head;
    mcb_pkg::word_t       rd_word;
    logic                 wr_pending;
    logic                 rd_pending;
    logic                 wr_last;
    logic                 rd_last;
    logic                 wr_stage_cplt;
    logic                 rd_stage_cplt;
    logic                 wr_full;
    logic                 wr_pop;
    logic                 rd_push;

    stage_if u_stg ();

    assign wr_rdy = !wr_full;

    cmd_tracker u_wr_trk (
        .clk_sdram (clk_sdram), .rst_n (rst_n), .load (wr_load),
        .load_addr (wr_addr), .load_len (wr_length), .stage_cplt (wr_stage_cplt),
        .pending (wr_pending), .addr (wr_cur_addr), .stage_len (wr_stage_len),
        .last (wr_last)
    );

    cmd_tracker u_rd_trk (
        .clk_sdram (clk_sdram), .rst_n (rst_n), .load (rd_load),
        .load_addr (rd_addr), .load_len (rd_length), .stage_cplt (rd_stage_cplt),
        .pending (rd_pending), .addr (rd_cur_addr), .stage_len (rd_stage_len),
        .last (rd_last)
    );

    stage_sequencer u_seq (
        .clk_sdram (clk_sdram), .rst_n (rst_n),
        .wr_pending (wr_pending), .rd_pending (rd_pending),
        .wr_addr (wr_cur_addr), .rd_addr (rd_cur_addr),
        .wr_stage_len (wr_stage_len), .rd_stage_len (rd_stage_len),
        .wr_last (wr_last), .rd_last (rd_last),
        .wr_fifo_cnt (wr_fifo_cnt), .rd_fifo_cnt (rd_fifo_cnt),
        .wr_stage_cplt (wr_stage_cplt), .rd_stage_cplt (rd_stage_cplt),
        .wr_done (wr_done), .rd_done (rd_done), .stg (u_stg.seq)
    );

    wb_burst_master u_mst (
        .clk_sdram (clk_sdram), .rst_n (rst_n), .stg (u_stg.master),
        .wr_word (wr_head), .wr_pop (wr_pop), .rd_word (rd_word), .rd_push (rd_push),
        .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
        .wb_dat_w (wb_dat_w), .wb_dat_r (wb_dat_r), .wb_ack (wb_ack)
    );

    // user data in, burst data out
    word_fifo u_wr_fifo (
        .clk_sdram (clk_sdram), .rst_n (rst_n), .push (wr_req && wr_rdy), .din (din),
        .pop (wr_pop), .dout (wr_head), .empty (), .full (wr_full), .cnt (wr_fifo_cnt)
    );

    // burst data in, user data out
    word_fifo u_rd_fifo (
        .clk_sdram (clk_sdram), .rst_n (rst_n), .push (rd_push), .din (rd_word),
        .pop (rd_req), .dout (dout), .empty (rd_fifo_empty), .full (),
        .cnt (rd_fifo_cnt)
    );

endmodule

// ==== word_fifo.sv ====
`timescale 1ns/1ps

module word_fifo (
    input  logic               clk_sdram,
    input  logic               rst_n,
    input  logic               push,
    input  mcb_pkg::word_t     din,
    input  logic               pop,
    output mcb_pkg::word_t     dout,    // head word, valid while not empty
    output logic               empty,
    output logic               full,
    output mcb_pkg::fifo_cnt_t cnt
);

    mcb_pkg::word_t            mem [mcb_pkg::FIFO_DEPTH];
    logic [mcb_pkg::PTR_W-1:0] wr_ptr;   // wraps at depth
    logic [mcb_pkg::PTR_W-1:0] rd_ptr;

    assign dout  = mem[rd_ptr];          // show-ahead read
    assign empty = (cnt == '0);
    assign full  = (cnt == mcb_pkg::fifo_cnt_t'(mcb_pkg::FIFO_DEPTH));

    always_ff @(posedge clk_sdram) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cnt    <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   cnt <= cnt + 1'b1;
                2'b01:   cnt <= cnt - 1'b1;
                default: cnt <= cnt;       // none, or both in one cycle
            endcase
        end
    end

    a_no_overflow: assert property (
        @(posedge clk_sdram) disable iff (!rst_n)
        !(push && full)
    );

    a_no_underflow: assert property (
        @(posedge clk_sdram) disable iff (!rst_n)
        !(pop && empty)
    );

endmodule

// ==== wb_burst_master.sv ====
`timescale 1ns/1ps

module wb_burst_master (
    input  logic                 clk_sdram,
    input  logic                 rst_n,
    stage_if.master              stg,
    input  mcb_pkg::word_t       wr_word,    // write FIFO head
    output logic                 wr_pop,
    output mcb_pkg::word_t       rd_word,
    output logic                 rd_push,
    output logic                 wb_cyc,
    output logic                 wb_stb,
    output logic                 wb_we,
    output mcb_pkg::sdram_addr_u wb_adr,
    output mcb_pkg::word_t       wb_dat_w,
    input  mcb_pkg::word_t       wb_dat_r,
    input  logic                 wb_ack
);

    mcb_pkg::stage_len_t beat_cnt;   // acked words this stage
    mcb_pkg::stage_len_t len_r;      // stage length latched at start
    logic                last_beat;

    assign stg.beat  = wb_stb && wb_ack;
    assign last_beat = stg.beat && ((beat_cnt + 1'b1) == len_r);
    assign stg.busy  = wb_cyc && !last_beat;   // drops in the final ack cycle

    assign wb_dat_w = wr_word;                  // FIFO head follows each pop
    assign rd_word  = wb_dat_r;
    assign wr_pop   = stg.beat && wb_we;
    assign rd_push  = stg.beat && !wb_we;

    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            wb_cyc   <= 1'b0;
            wb_stb   <= 1'b0;
            wb_we    <= 1'b0;
            beat_cnt <= '0;
        end else if (stg.start) begin
            wb_cyc   <= 1'b1;                   // held for the whole stage
            wb_stb   <= 1'b1;
            wb_we    <= stg.we;
            beat_cnt <= '0;
        end else if (stg.beat) begin
            beat_cnt <= beat_cnt + 1'b1;
            if (last_beat) begin
                wb_cyc <= 1'b0;
                wb_stb <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_sdram) begin
        if (stg.start) begin
            len_r  <= stg.len;
            wb_adr <= stg.addr;
        end else if (stg.beat) begin
            wb_adr.flat <= wb_adr.flat + 1'b1;  // next word after each ack
        end
    end

    a_stb_in_cyc: assert property (
        @(posedge clk_sdram) disable iff (!rst_n)
        wb_stb |-> wb_cyc
    );

    a_beats_bounded: assert property (
        @(posedge clk_sdram) disable iff (!rst_n)
        wb_cyc |-> (beat_cnt <= len_r)
    );

endmodule

// ==== stage_sequencer.sv ====
`timescale 1ns/1ps

module stage_sequencer (
    input  logic                 clk_sdram,
    input  logic                 rst_n,
    input  logic                 wr_pending,
    input  logic                 rd_pending,
    input  mcb_pkg::sdram_addr_u wr_addr,
    input  mcb_pkg::sdram_addr_u rd_addr,
    input  mcb_pkg::stage_len_t  wr_stage_len,
    input  mcb_pkg::stage_len_t  rd_stage_len,
    input  logic                 wr_last,
    input  logic                 rd_last,
    input  mcb_pkg::fifo_cnt_t   wr_fifo_cnt,   // words waiting in write FIFO
    input  mcb_pkg::fifo_cnt_t   rd_fifo_cnt,   // words held in read FIFO
    output logic                 wr_stage_cplt,
    output logic                 rd_stage_cplt,
    output logic                 wr_done,
    output logic                 rd_done,
    stage_if.seq                 stg
);

    mcb_pkg::seq_state_e      state;
    mcb_pkg::seq_state_e      state_nxt;
    logic                     toggle;   // 1 gives reads priority next
    logic                     wr_ok;
    logic                     rd_ok;
    logic [mcb_pkg::CNT_W:0]  rd_need;  // read FIFO fill after the stage

    // write stage needs its whole length already buffered
    assign wr_ok   = wr_pending && (wr_fifo_cnt >= wr_stage_len);
    // read stage needs room for every word it brings back
    assign rd_need = {1'b0, rd_fifo_cnt} + {1'b0, rd_stage_len};
    assign rd_ok   = rd_pending && (rd_need <= mcb_pkg::FIFO_DEPTH);

    always_comb begin
        state_nxt = state;
        case (state)
            mcb_pkg::IDLE: begin
                if (wr_ok && (!rd_ok || !toggle)) begin
                    state_nxt = mcb_pkg::PRE_WR;
                end else if (rd_ok) begin
                    state_nxt = mcb_pkg::PRE_RD;
                end
            end
            mcb_pkg::PRE_WR:        state_nxt = mcb_pkg::WRITING;
            mcb_pkg::WRITING:       if (!stg.busy) state_nxt = mcb_pkg::WR_STAGE_CPLT;
            mcb_pkg::WR_STAGE_CPLT: state_nxt = wr_last ? mcb_pkg::WR_DONE : mcb_pkg::IDLE;
            mcb_pkg::PRE_RD:        state_nxt = mcb_pkg::READING;
            mcb_pkg::READING:       if (!stg.busy) state_nxt = mcb_pkg::RD_STAGE_CPLT;
            mcb_pkg::RD_STAGE_CPLT: state_nxt = rd_last ? mcb_pkg::RD_DONE : mcb_pkg::IDLE;
            default:                state_nxt = mcb_pkg::IDLE;   // both DONE states too
        endcase
    end

    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            state  <= mcb_pkg::IDLE;
            toggle <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == mcb_pkg::WR_STAGE_CPLT) begin
                toggle <= 1'b1;                 // read gets the next turn
            end else if (state == mcb_pkg::RD_STAGE_CPLT) begin
                toggle <= 1'b0;
            end
        end
    end

    assign wr_stage_cplt = (state == mcb_pkg::WR_STAGE_CPLT);
    assign rd_stage_cplt = (state == mcb_pkg::RD_STAGE_CPLT);
    assign wr_done       = (state == mcb_pkg::WR_DONE);    // two cycles after last ack
    assign rd_done       = (state == mcb_pkg::RD_DONE);

    // stage request, taken by the master in PRE state
    assign stg.start = (state == mcb_pkg::PRE_WR) || (state == mcb_pkg::PRE_RD);
    assign stg.we    = (state == mcb_pkg::PRE_WR);
    assign stg.addr  = (state == mcb_pkg::PRE_WR) ? wr_addr : rd_addr;
    assign stg.len   = (state == mcb_pkg::PRE_WR) ? wr_stage_len : rd_stage_len;

    a_cplt_exclusive: assert property (
        @(posedge clk_sdram) disable iff (!rst_n)
        !(wr_stage_cplt && rd_stage_cplt)
    );

    // master must have finished the previous burst
    a_start_when_idle: assert property (
        @(posedge clk_sdram) disable iff (!rst_n)
        stg.start |-> !stg.busy
    );

endmodule

// ==== cmd_tracker.sv ====
`timescale 1ns/1ps

module cmd_tracker (
    input  logic                 clk_sdram,
    input  logic                 rst_n,
    input  logic                 load,        // single-cycle load request
    input  mcb_pkg::sdram_addr_u load_addr,
    input  mcb_pkg::len_t        load_len,
    input  logic                 stage_cplt,  // from sequencer, one stage retired
    output logic                 pending,
    output mcb_pkg::sdram_addr_u addr,
    output mcb_pkg::stage_len_t  stage_len,
    output logic                 last         // current stage empties the transaction
);

    mcb_pkg::len_t rem;        // words still to move
    mcb_pkg::len_t page_room;  // words left before the page end
    logic          take;       // accepted load

    // loads during a pending transaction or of zero length are dropped
    assign take = load && !pending && (load_len != '0);

    assign page_room = mcb_pkg::len_t'(mcb_pkg::PAGE_WORDS) - mcb_pkg::len_t'(addr.loc.col);

    // stage is the shorter of what remains and what fits in the page
    assign last      = (rem <= page_room);
    assign stage_len = last ? mcb_pkg::stage_len_t'(rem)
                            : mcb_pkg::stage_len_t'(page_room);

    always_ff @(posedge clk_sdram or negedge rst_n) begin
        if (!rst_n) begin
            pending <= 1'b0;
        end else if (take) begin
            pending <= 1'b1;                    // visible one cycle after load
        end else if (stage_cplt && last) begin
            pending <= 1'b0;                    // final stage retired
        end
    end

    always_ff @(posedge clk_sdram) begin
        if (take) begin
            addr <= load_addr;
            rem  <= load_len;
        end else if (stage_cplt) begin
            rem       <= rem - mcb_pkg::len_t'(stage_len);
            addr.flat <= addr.flat + mcb_pkg::len_t'(stage_len);  // flat step, may cross row/bank
        end
    end

    // sequencer must only retire stages of a live transaction
    a_cplt_needs_pending: assert property (
        @(posedge clk_sdram) disable iff (!rst_n)
        stage_cplt |-> pending
    );

endmodule

// ==== stage_if.sv ====
`timescale 1ns/1ps

interface stage_if;

    logic                 start;     // one-cycle request, only while busy low
    logic                 we;        // 1 = write stage
    mcb_pkg::sdram_addr_u addr;      // first word of the stage
    mcb_pkg::stage_len_t  len;       // words in the stage
    logic                 busy;      // burst in flight
    logic                 beat;      // one acked word

    modport seq (
        output start, we, addr, len,
        input  busy, beat
    );

    modport master (
        input  start, we, addr, len,
        output busy, beat
    );

endinterface

// ==== mcb_pkg.sv ====
package mcb_pkg;

    localparam int BANK_W     = 2;                        // bank select bits
    localparam int ROW_W      = 13;                       // row bits
    localparam int COL_W      = 9;                        // column bits
    localparam int ADDR_W     = BANK_W + ROW_W + COL_W;   // 24-bit word address
    localparam int PAGE_WORDS = 1 << COL_W;               // 512 words per column page
    localparam int FIFO_DEPTH = 1024;                     // words per FIFO
    localparam int PTR_W      = $clog2(FIFO_DEPTH);       // FIFO pointer width
    localparam int CNT_W      = PTR_W + 1;                // 0..FIFO_DEPTH
    localparam int DATA_W     = 16;                       // word width

    typedef logic [DATA_W-1:0] word_t;
    typedef logic [ADDR_W-1:0] len_t;                     // word count of a transaction
    typedef logic [CNT_W-1:0]  stage_len_t;               // never above PAGE_WORDS
    typedef logic [CNT_W-1:0]  fifo_cnt_t;

    // one address word, seen flat for stepping or split for page math
    typedef union packed {
        logic [ADDR_W-1:0] flat;                          // linear word address
        struct packed {
            logic [BANK_W-1:0] bank;
            logic [ROW_W-1:0]  row;
            logic [COL_W-1:0]  col;                       // position inside the page
        } loc;
    } sdram_addr_u;

    typedef enum logic [3:0] {
        IDLE          = 4'd0,
        PRE_WR        = 4'd1,
        WRITING       = 4'd2,
        WR_STAGE_CPLT = 4'd3,
        WR_DONE       = 4'd4,
        PRE_RD        = 4'd5,
        READING       = 4'd6,
        RD_STAGE_CPLT = 4'd7,
        RD_DONE       = 4'd8
    } seq_state_e;

endpackage
